// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module tb_idu

run: compile
	@out=$$(./obj_dir/Vtb_idu); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== dv/idu_input.txt ====
# inst pc gpr_wdata csr_wdata, ctrl: a_pc b_src alu br m2r mwr mre mop ex wcut csr zimm inv
# then rs1_data rs2_data imm csr_rdata trap_redirect trap_pc, all hex
00000000 0 0 0 0 0 1f 0 0 0 0 7 f 0 0 0 0 0 0 0 0 0 0
00628033 0 0 0 0 0 0 0 0 0 0 7 f 0 0 0 0 0 0 0 0 0 0
30502073 0 0 0 0 1 1f 0 0 0 0 7 1 0 1 0 0 0 0 305 0 0 0
fff00293 0 123456789abcdef0 0 0 1 0 0 0 0 0 7 f 0 0 0 0 0 0 ffffffffffffffff 0 0 0
00528033 0 0 0 0 0 0 0 0 0 0 7 f 0 0 0 0 123456789abcdef0 123456789abcdef0 0 0 0 0
7ff00013 0 dead 0 0 1 0 0 0 0 0 7 f 0 0 0 0 0 0 7ff 0 0 0
80000037 0 0 0 0 1 f 0 0 0 0 7 f 0 0 0 0 0 0 ffffffff80000000 0 0 0
12345017 0 0 0 1 1 0 0 0 0 0 7 f 0 0 0 0 0 0 12345000 0 0 0
ffdff06f 0 0 0 1 2 0 1 0 0 0 7 f 0 0 0 0 0 0 fffffffffffffffc 0 0 0
01000067 0 0 0 1 2 0 2 0 0 0 7 f 0 0 0 0 0 0 10 0 0 0
fe000ce3 0 0 0 0 0 2 4 0 0 0 7 f 0 0 0 0 0 0 fffffffffffffff8 0 0 0
00006463 0 0 0 0 0 3 6 0 0 0 7 f 0 0 0 0 0 0 8 0 0 0
ff003003 0 0 0 0 1 0 0 1 0 1 6 f 0 0 0 0 0 0 fffffffffffffff0 0 0 0
00404003 0 0 0 0 1 0 0 1 0 1 1 f 0 0 0 0 0 0 4 0 0 0
fe003e23 0 0 0 0 1 0 0 0 1 0 6 f 0 0 0 0 0 0 fffffffffffffffc 0 0 0
43f05013 0 0 0 0 1 9 0 0 0 0 7 f 0 0 0 0 0 0 43f 0 0 0
0010001b 0 0 0 0 1 0 0 0 0 0 7 f 1 0 0 0 0 0 1 0 0 0
40028033 0 0 0 0 0 1 0 0 0 0 7 f 0 0 0 0 123456789abcdef0 0 0 0 0 0
02002033 0 0 0 0 0 1a 0 0 0 0 7 f 0 0 0 0 0 0 0 0 0 0
0200503b 0 0 0 0 0 c 0 0 0 0 7 f 1 0 0 0 0 0 0 0 0 0
0000203b 0 0 0 0 0 1f 0 0 0 0 7 f 0 0 0 1 0 0 0 0 0 0
30501073 0 0 80000100 0 1 1f 0 0 0 0 7 0 0 1 0 0 0 123456789abcdef0 305 0 0 0
30502073 0 0 0 0 1 1f 0 0 0 0 7 1 0 1 0 0 0 123456789abcdef0 305 80000100 0 80000100
7c002073 0 0 0 0 1 1f 0 0 0 0 7 1 0 1 0 0 0 0 7c0 0 0 80000100
7c1ad073 0 0 0 0 0 1f 0 0 0 0 7 0 0 1 1 0 0 0 0 0 0 80000100
00000073 1000 0 0 0 0 1f 0 0 0 0 7 d 0 1 0 0 0 0 0 0 1 80000100
34102073 0 0 0 0 1 1f 0 0 0 0 7 1 0 1 0 0 0 0 341 1000 0 80000100
34202073 0 0 0 0 1 1f 0 0 0 0 7 1 0 1 0 0 0 0 342 b 0 80000100
30200073 0 0 0 0 0 1f 0 0 0 0 7 c 0 1 0 0 0 0 0 0 1 1000
00100073 0 0 0 0 1 1f 0 0 0 0 7 e 0 0 0 0 0 0 1 0 0 80000100

// ==== dv/tb_idu.sv ====
// drives idu_top from dv/idu_input.txt, one step per clock; outputs sampled at the falling edge
`timescale 1ns/1ps

module tb_idu;
  import idu_pkg::*;

  localparam int MAX_STEPS = 64;
  localparam int NCOL      = 23;

  logic            i_clk;
  logic            i_rst_n;
  logic [XLEN-1:0] i_pc;
  inst_u           i_inst;
  logic [XLEN-1:0] i_gpr_wdata;
  logic [XLEN-1:0] i_csr_wdata;
  idu_ctrl_t       o_ctrl;
  logic [XLEN-1:0] o_rs1_data;
  logic [XLEN-1:0] o_rs2_data;
  logic [XLEN-1:0] o_imm;
  logic [XLEN-1:0] o_zimm;
  logic [XLEN-1:0] o_csr_rdata;
  logic [XLEN-1:0] o_trap_pc;
  logic            o_trap_redirect;

  logic [63:0] tab [0:MAX_STEPS-1][0:NCOL-1];
  int          nsteps;
  int          errors;
  int          cycles;
  int          limit;

  idu_top u_dut (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_pc(i_pc), .i_inst(i_inst),
    .i_gpr_wdata(i_gpr_wdata), .i_csr_wdata(i_csr_wdata), .o_ctrl(o_ctrl),
    .o_rs1_data(o_rs1_data), .o_rs2_data(o_rs2_data), .o_imm(o_imm), .o_zimm(o_zimm),
    .o_csr_rdata(o_csr_rdata), .o_trap_pc(o_trap_pc), .o_trap_redirect(o_trap_redirect)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // lines starting with # are column notes
  task automatic load_steps(input int fd);
    string       line;
    logic [63:0] v [0:NCOL-1];
    int          n;
    while (!$feof(fd) && nsteps < MAX_STEPS) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                    v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21], v[22]);
        if (n == NCOL) begin
          for (int c = 0; c < NCOL; c++) tab[nsteps][c] = v[c];
          nsteps++;
        end else begin
          $display("data line %0d has %0d columns instead of %0d", nsteps, n, NCOL);
          errors++;
        end
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_step(input int s);
    idu_ctrl_t exp_ctrl;
    exp_ctrl.alu_a_pc   = tab[s][4][0];
    exp_ctrl.alu_b_src  = tab[s][5][1:0];
    exp_ctrl.alu_ctr    = tab[s][6][4:0];
    exp_ctrl.branch     = tab[s][7][2:0];
    exp_ctrl.mem_to_reg = tab[s][8][0];
    exp_ctrl.mem_wr     = tab[s][9][0];
    exp_ctrl.mem_re     = tab[s][10][0];
    exp_ctrl.mem_op     = tab[s][11][2:0];
    exp_ctrl.ex_ctr     = tab[s][12][3:0];
    exp_ctrl.word_cut   = tab[s][13][0];
    exp_ctrl.sel_csr    = tab[s][14][0];
    exp_ctrl.sel_zimm   = tab[s][15][0];
    exp_ctrl.invalid    = tab[s][16][0];
    compare_value("o_ctrl", {39'b0, exp_ctrl}, {39'b0, o_ctrl});
    compare_value("o_rs1_data", tab[s][17], o_rs1_data);
    compare_value("o_rs2_data", tab[s][18], o_rs2_data);
    compare_value("o_imm", tab[s][19], o_imm);
    compare_value("o_zimm", {59'b0, tab[s][0][19:15]}, o_zimm); // rs1 field zero-extended
    compare_value("o_csr_rdata", tab[s][20], o_csr_rdata);
    compare_value("o_trap_redirect", {63'b0, tab[s][21][0]}, {63'b0, o_trap_redirect});
    compare_value("o_trap_pc", tab[s][22], o_trap_pc);
  endtask

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: run passed %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    int fd;
    i_rst_n     = 1'b0;
    i_pc        = '0;
    i_inst      = '0;
    i_gpr_wdata = '0;
    i_csr_wdata = '0;
    nsteps      = 0;
    errors      = 0;
    cycles      = 0;
    limit       = 0;
    fd = $fopen("dv/idu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the data file dv/idu_input.txt");
      errors++;
    end else begin
      load_steps(fd);
      $fclose(fd);
    end
    limit = 4 * nsteps + 20;
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int s = 0; s < nsteps; s++) begin
      @(posedge i_clk);
      i_inst      <= tab[s][0][31:0];
      i_pc        <= tab[s][1];
      i_gpr_wdata <= tab[s][2];
      i_csr_wdata <= tab[s][3];
      @(negedge i_clk); // settled before the write edge
      check_step(s);
    end
    $display("errors: %0d over %0d steps", errors, nsteps);
    if (errors == 0 && nsteps > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/idu_pkg.sv
src/idu_decoder.sv
src/idu_imm_gen.sv
src/idu_gpr.sv
src/idu_csr.sv
src/idu_top.sv
dv/tb_idu.sv

// ==== src/idu_csr.sv ====
// machine CSRs mstatus, mtvec, mepc, mcause; other addresses read zero, only ecall traps
`timescale 1ns/1ps

module idu_csr (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  idu_pkg::csr_req_t           i_req,
  input  logic [idu_pkg::XLEN-1:0]    i_wdata,
  input  logic [idu_pkg::XLEN-1:0]    i_epc,
  output logic [idu_pkg::XLEN-1:0]    o_rdata,
  output logic [idu_pkg::XLEN-1:0]    o_trap_pc,
  output logic                        o_trap_redirect
);
  import idu_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_req.wen) begin
        case (i_req.addr)
          CSR_MSTATUS: mstatus <= i_wdata;
          CSR_MTVEC:   mtvec   <= i_wdata;
          CSR_MEPC:    mepc    <= i_wdata;
          CSR_MCAUSE:  mcause  <= i_wdata;
          default: ; // unknown csr ignored
        endcase
      end
      if (i_req.raise_intr) begin
        mepc   <= i_epc; // trap entry wins
        mcause <= CAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_req.ren) begin
      case (i_req.addr)
        CSR_MSTATUS: o_rdata = mstatus;
        CSR_MTVEC:   o_rdata = mtvec;
        CSR_MEPC:    o_rdata = mepc;
        CSR_MCAUSE:  o_rdata = mcause;
        default:     o_rdata = '0;
      endcase
    end
  end

  assign o_trap_pc       = i_req.intr_ret ? mepc : mtvec;
  assign o_trap_redirect = i_req.raise_intr | i_req.intr_ret;

  a_trap_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_req.raise_intr && i_req.intr_ret));

endmodule

// ==== src/idu_decoder.sv ====
// combinational RV64IM decoder; csrrwi does not write rd and unsupported words flag invalid
`timescale 1ns/1ps

module idu_decoder (
  input  idu_pkg::inst_u     i_inst,
  output idu_pkg::idu_ctrl_t o_ctrl,
  output idu_pkg::imm_fmt_e  o_imm_fmt,
  output logic               o_gpr_wen,
  output idu_pkg::csr_req_t  o_csr_req
);
  import idu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_shift;
  logic       is_csrrw;
  logic       is_csrrs;
  logic       is_csrrwi;
  logic       is_ecall;
  logic       is_mret;

  // alu code of the register-register forms
  function automatic logic [4:0] op_alu(input logic [2:0] f3, input logic [6:0] f7);
    logic [4:0] code;
    code = ALU_INVALID;
    case (f7)
      7'b0000000: begin
        case (f3)
          3'd0: code = ALU_ADD;
          3'd1: code = ALU_SLL;
          3'd2: code = ALU_SLT;
          3'd3: code = ALU_SLTU;
          3'd4: code = ALU_XOR;
          3'd5: code = ALU_SRL;
          3'd6: code = ALU_OR;
          default: code = ALU_AND;
        endcase
      end
      7'b0100000: begin
        if (f3 == 3'd0) code = ALU_SUB;
        else if (f3 == 3'd5) code = ALU_SRA;
      end
      7'b0000001: begin
        case (f3)
          3'd0: code = ALU_MUL;
          3'd1: code = ALU_MULH;
          3'd2: code = ALU_MULHSU;
          3'd3: code = ALU_MULHU;
          3'd4: code = ALU_DIV;
          3'd5: code = ALU_DIVU;
          3'd6: code = ALU_REM;
          default: code = ALU_REMU;
        endcase
      end
      default: ;
    endcase
    return code;
  endfunction

  assign opcode    = i_inst.r.opcode;
  assign funct3    = i_inst.r.funct3;
  assign funct7    = i_inst.r.funct7;
  assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
  assign is_csrrw  = (opcode == OPC_SYSTEM) && (funct3 == 3'b001);
  assign is_csrrs  = (opcode == OPC_SYSTEM) && (funct3 == 3'b010);
  assign is_csrrwi = (opcode == OPC_SYSTEM) && (funct3 == 3'b101);
  assign is_ecall  = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) && (i_inst.i.imm == '0);
  assign is_mret   = (i_inst == INST_MRET);

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.alu_ctr = ALU_INVALID;
    o_ctrl.branch  = BR_NONE;
    o_ctrl.mem_op  = MEM_NONE;
    o_ctrl.ex_ctr  = EX_NONE;
    o_imm_fmt      = IMM_NONE;
    o_gpr_wen      = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm_fmt = IMM_U;
        o_ctrl.alu_ctr = ALU_COPY_IMM;
        o_ctrl.alu_b_src = 2'd1;
        o_gpr_wen = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm_fmt = IMM_U;
        o_ctrl.alu_ctr = ALU_ADD;
        o_ctrl.alu_a_pc = 1'b1;
        o_ctrl.alu_b_src = 2'd1;
        o_gpr_wen = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        if (opcode == OPC_JAL || funct3 == 3'b000) begin
          o_imm_fmt = (opcode == OPC_JAL) ? IMM_J : IMM_I;
          o_ctrl.branch = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
          o_ctrl.alu_ctr = ALU_ADD; // pc + 4 for the link
          o_ctrl.alu_a_pc = 1'b1;
          o_ctrl.alu_b_src = 2'd2;
          o_gpr_wen = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3[2:1] != 2'b01) begin
          o_imm_fmt = IMM_B;
          o_ctrl.branch = {1'b1, funct3[2], funct3[0]}; // unsigned forms share lt/ge
          o_ctrl.alu_ctr = funct3[1] ? ALU_SLTU : ALU_SLT;
        end
      end
      OPC_LOAD: begin
        if (funct3 != 3'b111) begin
          o_imm_fmt = IMM_I;
          o_ctrl.alu_ctr = ALU_ADD;
          o_ctrl.alu_b_src = 2'd1;
          o_ctrl.mem_to_reg = 1'b1;
          o_ctrl.mem_re = 1'b1;
          o_ctrl.mem_op = {funct3[1:0], funct3[2]}; // width then unsigned bit
          o_gpr_wen = 1'b1;
        end
      end
      OPC_STORE: begin
        if (!funct3[2]) begin
          o_imm_fmt = IMM_S;
          o_ctrl.alu_ctr = ALU_ADD;
          o_ctrl.alu_b_src = 2'd1;
          o_ctrl.mem_wr = 1'b1;
          o_ctrl.mem_op = {funct3[1:0], 1'b0};
        end
      end
      OPC_OP_IMM, OPC_OP_IMM_W: begin
        if (opcode == OPC_OP_IMM) begin
          o_ctrl.alu_ctr = op_alu(funct3, is_shift ? {funct7[6:1], 1'b0} : 7'b0); // 6-bit shamt
        end else if (funct3 == 3'b000) begin
          o_ctrl.alu_ctr = ALU_ADD;
        end else if (is_shift && funct7 != 7'b0000001) begin
          o_ctrl.alu_ctr = op_alu(funct3, funct7);
        end
        if (o_ctrl.alu_ctr != ALU_INVALID) begin
          o_imm_fmt = IMM_I;
          o_ctrl.alu_b_src = 2'd1;
          o_ctrl.word_cut = (opcode == OPC_OP_IMM_W);
          o_gpr_wen = 1'b1;
        end
      end
      OPC_OP, OPC_OP_W: begin
        if (opcode == OPC_OP) begin
          o_ctrl.alu_ctr = op_alu(funct3, funct7);
        end else if ((funct7 == 7'b0000001) ? (funct3 == 3'b000 || funct3[2])
                                             : (funct3 == 3'b000 || is_shift)) begin
          o_ctrl.alu_ctr = op_alu(funct3, funct7);
        end
        if (o_ctrl.alu_ctr != ALU_INVALID) begin
          o_ctrl.word_cut = (opcode == OPC_OP_W);
          o_gpr_wen = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            if (is_mret) begin
              o_ctrl.ex_ctr = EX_MRET;
            end else if (is_ecall) begin
              o_ctrl.ex_ctr = EX_ECALL;
            end else if (i_inst.i.imm == 12'h001) begin
              o_ctrl.ex_ctr = EX_EBREAK;
              o_imm_fmt = IMM_I;
              o_ctrl.alu_b_src = 2'd1;
              o_gpr_wen = 1'b1;
            end
          end
          3'b001, 3'b010: begin
            o_ctrl.ex_ctr = funct3[1] ? EX_CSRRS : EX_CSRRW;
            o_imm_fmt = IMM_I;
            o_ctrl.alu_b_src = 2'd1;
            o_gpr_wen = 1'b1;
          end
          3'b101: o_ctrl.ex_ctr = EX_CSRRW; // csrrwi
          default: ;
        endcase
      end
      default: ;
    endcase
    o_ctrl.sel_csr  = is_csrrw | is_csrrs | is_csrrwi | is_ecall | is_mret;
    o_ctrl.sel_zimm = is_csrrwi;
    o_ctrl.invalid  = (o_ctrl.alu_ctr == ALU_INVALID) && (o_ctrl.ex_ctr == EX_NONE) &&
                      (i_inst != '0);
  end

  assign o_csr_req.ren        = o_ctrl.sel_csr && (!is_csrrw || i_inst.r.rd != '0);
  assign o_csr_req.wen        = o_ctrl.sel_csr && (!is_csrrs || i_inst.r.rs1 != '0);
  assign o_csr_req.raise_intr = is_ecall;
  assign o_csr_req.intr_ret   = is_mret;
  assign o_csr_req.addr       = i_inst.i.imm;

endmodule

// ==== src/idu_gpr.sv ====
// 32 x 64 register file, two async reads, one write per clock; x0 is never stored
`timescale 1ns/1ps

module idu_gpr (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic [idu_pkg::REG_ADDR_W-1:0]   i_raddr1,
  input  logic [idu_pkg::REG_ADDR_W-1:0]   i_raddr2,
  input  logic [idu_pkg::REG_ADDR_W-1:0]   i_waddr,
  input  logic [idu_pkg::XLEN-1:0]         i_wdata,
  input  logic                             i_wen,
  output logic [idu_pkg::XLEN-1:0]         o_rdata1,
  output logic [idu_pkg::XLEN-1:0]         o_rdata2
);
  import idu_pkg::*;

  logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 1; k < 2**REG_ADDR_W; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata; // x0 writes dropped
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // a written register reads back on port 1 in the next cycle
  a_wr_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wen && i_waddr != '0) |=> (i_raddr1 != $past(i_waddr) || o_rdata1 == $past(i_wdata)));

endmodule

// ==== src/idu_imm_gen.sv ====
// immediate builder; the format comes from the decoder and IMM_NONE yields zero
`timescale 1ns/1ps

module idu_imm_gen (
  input  idu_pkg::inst_u                i_inst,
  input  idu_pkg::imm_fmt_e             i_fmt,
  output logic [idu_pkg::XLEN-1:0]      o_imm,
  output logic [idu_pkg::XLEN-1:0]      o_zimm
);
  import idu_pkg::*;

  always_comb begin
    case (i_fmt)
      IMM_I: o_imm = {{(XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
      IMM_U: o_imm = {{(XLEN-32){i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
      IMM_S: o_imm = {{(XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
      IMM_B: begin
        o_imm = {{(XLEN-12){i_inst.b.imm12}}, i_inst.b.imm11, i_inst.b.imm10_5,
                 i_inst.b.imm4_1, 1'b0};
      end
      IMM_J: begin
        o_imm = {{(XLEN-20){i_inst.j.imm20}}, i_inst.j.imm19_12, i_inst.j.imm11,
                 i_inst.j.imm10_1, 1'b0};
      end
      default: o_imm = '0;
    endcase
  end

  assign o_zimm = {{(XLEN-REG_ADDR_W){1'b0}}, i_inst.r.rs1}; // csr immediate form

endmodule

// ==== src/idu_pkg.sv ====
// shared RV64IM decode definitions; only four machine CSRs exist and the control codes are fixed
package idu_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_W     = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  localparam logic [ILEN-1:0] INST_MRET = 32'h3020_0073; // only one encoding

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

  localparam logic [4:0] ALU_ADD      = 5'd0;
  localparam logic [4:0] ALU_SUB      = 5'd1;
  localparam logic [4:0] ALU_SLT      = 5'd2;
  localparam logic [4:0] ALU_SLTU     = 5'd3;
  localparam logic [4:0] ALU_XOR      = 5'd4;
  localparam logic [4:0] ALU_AND      = 5'd5;
  localparam logic [4:0] ALU_OR       = 5'd6;
  localparam logic [4:0] ALU_SLL      = 5'd7;
  localparam logic [4:0] ALU_SRL      = 5'd8;
  localparam logic [4:0] ALU_SRA      = 5'd9;
  localparam logic [4:0] ALU_MUL      = 5'd10;
  localparam logic [4:0] ALU_DIV      = 5'd11;
  localparam logic [4:0] ALU_DIVU     = 5'd12;
  localparam logic [4:0] ALU_REM      = 5'd13;
  localparam logic [4:0] ALU_REMU     = 5'd14;
  localparam logic [4:0] ALU_COPY_IMM = 5'd15;
  localparam logic [4:0] ALU_MULH     = 5'd25;
  localparam logic [4:0] ALU_MULHSU   = 5'd26;
  localparam logic [4:0] ALU_MULHU    = 5'd27;
  localparam logic [4:0] ALU_INVALID  = 5'd31;

  localparam logic [2:0] BR_NONE = 3'd0;
  localparam logic [2:0] BR_JAL  = 3'd1;
  localparam logic [2:0] BR_JALR = 3'd2;
  localparam logic [2:0] BR_EQ   = 3'd4;
  localparam logic [2:0] BR_NE   = 3'd5;
  localparam logic [2:0] BR_LT   = 3'd6;
  localparam logic [2:0] BR_GE   = 3'd7;

  localparam logic [2:0] MEM_B    = 3'd0;
  localparam logic [2:0] MEM_BU   = 3'd1;
  localparam logic [2:0] MEM_H    = 3'd2;
  localparam logic [2:0] MEM_HU   = 3'd3;
  localparam logic [2:0] MEM_W    = 3'd4;
  localparam logic [2:0] MEM_WU   = 3'd5;
  localparam logic [2:0] MEM_D    = 3'd6;
  localparam logic [2:0] MEM_NONE = 3'd7;

  localparam logic [3:0] EX_CSRRW  = 4'd0;
  localparam logic [3:0] EX_CSRRS  = 4'd1;
  localparam logic [3:0] EX_MRET   = 4'd12;
  localparam logic [3:0] EX_ECALL  = 4'd13;
  localparam logic [3:0] EX_EBREAK = 4'd14;
  localparam logic [3:0] EX_NONE   = 4'd15;

  typedef enum logic [2:0] {IMM_I, IMM_U, IMM_S, IMM_B, IMM_J, IMM_NONE} imm_fmt_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

  typedef struct packed {
    logic       alu_a_pc;
    logic [1:0] alu_b_src; // 0 rs2, 1 imm, 2 const 4
    logic [4:0] alu_ctr;
    logic [2:0] branch;
    logic       mem_to_reg;
    logic       mem_wr;
    logic       mem_re;
    logic [2:0] mem_op;
    logic [3:0] ex_ctr;
    logic       word_cut;
    logic       sel_csr;
    logic       sel_zimm;
    logic       invalid;
  } idu_ctrl_t;

  typedef struct packed {
    logic                  ren;
    logic                  wen;
    logic                  raise_intr;
    logic                  intr_ret;
    logic [CSR_ADDR_W-1:0] addr;
  } csr_req_t;

endpackage

// ==== src/idu_top.sv ====
// single-cycle decode stage; no handshake, one instruction per clock, writes land on the edge
`timescale 1ns/1ps

module idu_top (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic [idu_pkg::XLEN-1:0]   i_pc,
  input  idu_pkg::inst_u             i_inst,
  input  logic [idu_pkg::XLEN-1:0]   i_gpr_wdata,
  input  logic [idu_pkg::XLEN-1:0]   i_csr_wdata,
  output idu_pkg::idu_ctrl_t         o_ctrl,
  output logic [idu_pkg::XLEN-1:0]   o_rs1_data,
  output logic [idu_pkg::XLEN-1:0]   o_rs2_data,
  output logic [idu_pkg::XLEN-1:0]   o_imm,
  output logic [idu_pkg::XLEN-1:0]   o_zimm,
  output logic [idu_pkg::XLEN-1:0]   o_csr_rdata,
  output logic [idu_pkg::XLEN-1:0]   o_trap_pc,
  output logic                       o_trap_redirect
);
  import idu_pkg::*;

  imm_fmt_e imm_fmt;
  logic     gpr_wen;
  csr_req_t csr_req;

  idu_decoder u_decoder (
    .i_inst    (i_inst),
    .o_ctrl    (o_ctrl),
    .o_imm_fmt (imm_fmt),
    .o_gpr_wen (gpr_wen),
    .o_csr_req (csr_req)
  );

  idu_imm_gen u_imm_gen (
    .i_inst (i_inst),
    .i_fmt  (imm_fmt),
    .o_imm  (o_imm),
    .o_zimm (o_zimm)
  );

  idu_gpr u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (i_inst.r.rs1),
    .i_raddr2 (i_inst.r.rs2),
    .i_waddr  (i_inst.r.rd),
    .i_wdata  (i_gpr_wdata),
    .i_wen    (gpr_wen),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  idu_csr u_csr (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_req           (csr_req),
    .i_wdata         (i_csr_wdata),
    .i_epc           (i_pc), // ecall saves its own pc
    .o_rdata         (o_csr_rdata),
    .o_trap_pc       (o_trap_pc),
    .o_trap_redirect (o_trap_redirect)
  );

endmodule
